// File: common/mr_ctl_defs.svh
`ifndef MR_CTL_DEFS_SVH
`define MR_CTL_DEFS_SVH

// Client channels and channel field width
`define MR_CHNL_NUM         5
`define MR_CHNL_LOG         3

// 32 outstanding requests per channel
`define MR_LOCAL_TAG_LOG    5
`define MR_TAG_LOG          8

`define MR_QPN_LOG          8

// 16-entry MR table
`define MR_KEY_LOG          4

`define MR_OFFSET_WIDTH     32
`define MR_ADDR_WIDTH       48

// Error bit above the physical address
`define MR_RESP_DATA_WIDTH  49

// QPN above the zero-extended local tag
`define MR_RESP_HEAD_WIDTH  16

`endif

// File: common/mr_ctl_pkg.sv
`include "mr_ctl_defs.svh"

package mr_ctl_pkg;

    typedef struct packed {
        logic [`MR_CHNL_LOG-1:0]      chnl;
        logic [`MR_LOCAL_TAG_LOG-1:0] local_tag;
    } mr_tag_fields_t;

    // Flat view indexes the tag-to-QPN table
    typedef union packed {
        logic [`MR_TAG_LOG-1:0] flat;
        mr_tag_fields_t         f;
    } mr_tag_u;

    // Channel numbering
    localparam int CHNL_SQ      = 0;
    localparam int CHNL_RQ      = 1;
    localparam int CHNL_TX_REQ  = 2;
    localparam int CHNL_RX_REQ  = 3;
    localparam int CHNL_RX_RESP = 4;

endpackage

// File: mr_ctl/mr_req_sched.sv
`timescale 1ns/100ps
`include "mr_ctl_defs.svh"

module mr_req_sched (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [`MR_CHNL_NUM-1:0]                             req_valid,
    input  logic [`MR_CHNL_NUM-1:0][`MR_QPN_LOG-1:0]            req_qpn,
    input  logic [`MR_CHNL_NUM-1:0][`MR_KEY_LOG-1:0]            req_key,
    input  logic [`MR_CHNL_NUM-1:0][`MR_OFFSET_WIDTH-1:0]       req_offset,
    output logic [`MR_CHNL_NUM-1:0]                             req_ready,
    output logic                                                issue_valid,
    output mr_ctl_pkg::mr_tag_u                                 issue_tag,
    output logic [`MR_KEY_LOG-1:0]                              issue_key,
    output logic [`MR_OFFSET_WIDTH-1:0]                         issue_offset,
    input  logic                                                issue_ready,
    output logic                                                tbl_wr_en,
    output logic [`MR_TAG_LOG-1:0]                              tbl_wr_tag,
    output logic [`MR_QPN_LOG-1:0]                              tbl_wr_qpn,
    input  logic                                                release_valid,
    input  logic [`MR_CHNL_LOG-1:0]                             release_chnl
);

    localparam int NCH = `MR_CHNL_NUM;
    localparam int CL  = `MR_CHNL_LOG;
    localparam int LTL = `MR_LOCAL_TAG_LOG;

    logic [CL-1:0]            rr_ptr;
    logic [NCH-1:0][LTL-1:0]  tag_cnt;
    logic [NCH-1:0][LTL:0]    out_cnt;
    logic                     issue_free;
    logic                     grant_found;
    logic [CL-1:0]            grant_chnl;
    logic [NCH-1:0]           dec_vec;
    mr_ctl_pkg::mr_tag_u      new_tag;

    assign issue_free = !issue_valid || issue_ready;

    // Search starts at the pointer and skips channels at their tag limit
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_chnl  = '0;
        for (int i = 0; i < NCH; i++) begin
            idx = (int'(rr_ptr) + i) % NCH;
            if (issue_free && !grant_found && req_valid[idx] &&
                int'(out_cnt[idx]) < (1 << LTL)) begin
                grant_found = 1'b1;
                grant_chnl  = CL'(idx);
            end
        end
    end

    assign req_ready = grant_found ? (NCH'(1) << grant_chnl) : '0;
    assign dec_vec   = release_valid ? (NCH'(1) << release_chnl) : '0;

    always_comb begin
        new_tag.f.chnl      = grant_chnl;
        new_tag.f.local_tag = tag_cnt[grant_chnl];
    end

    // QPN goes to the mapping table on the request handshake
    assign tbl_wr_en  = grant_found;
    assign tbl_wr_tag = new_tag.flat;
    assign tbl_wr_qpn = req_qpn[grant_chnl];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rr_ptr      <= '0;
            tag_cnt     <= '0;
            out_cnt     <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (grant_found) begin
                rr_ptr              <= (grant_chnl == CL'(NCH - 1)) ? '0 : grant_chnl + 1'b1;
                tag_cnt[grant_chnl] <= tag_cnt[grant_chnl] + 1'b1;
                issue_valid         <= 1'b1;
            end else if (issue_ready) begin
                issue_valid <= 1'b0;
            end
            // Grant and release on one channel cancel out
            for (int c = 0; c < NCH; c++) begin
                if (req_ready[c] && !dec_vec[c]) begin
                    out_cnt[c] <= out_cnt[c] + 1'b1;
                end else if (dec_vec[c] && !req_ready[c]) begin
                    out_cnt[c] <= out_cnt[c] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_found) begin
            issue_tag    <= new_tag;
            issue_key    <= req_key[grant_chnl];
            issue_offset <= req_offset[grant_chnl];
        end
    end

    for (genvar c = 0; c < NCH; c++) begin : g_cnt_chk
        // A release must match an earlier grant from the same channel
        a_cnt_floor: assert property (@(posedge clk) disable iff (rst)
            dec_vec[c] |-> out_cnt[c] != '0);
    end

endmodule

// File: mr_ctl/tag_qpn_table.sv
`timescale 1ns/100ps
`include "mr_ctl_defs.svh"

module tag_qpn_table (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  logic [`MR_TAG_LOG-1:0]   wr_tag,
    input  logic [`MR_QPN_LOG-1:0]   wr_qpn,
    input  logic [`MR_TAG_LOG-1:0]   rd_tag,
    input  logic                     rd_done,
    output logic [`MR_QPN_LOG-1:0]   rd_qpn
);

    localparam int DEPTH = 1 << `MR_TAG_LOG;

    logic [DEPTH-1:0][`MR_QPN_LOG-1:0] qpn_mem;
    logic [DEPTH-1:0]                  busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            qpn_mem <= '0;
            busy    <= '0;
        end else begin
            if (rd_done) begin
                busy[rd_tag] <= 1'b0;
            end
            if (wr_en) begin
                qpn_mem[wr_tag] <= wr_qpn;
                busy[wr_tag]    <= 1'b1;
            end
        end
    end

    assign rd_qpn = qpn_mem[rd_tag];

    // Tag reuse only after the dispatcher has handed the old response out
    a_no_reuse: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !busy[wr_tag]);

endmodule

// File: mr_ctl/mr_translate.sv
`timescale 1ns/100ps
`include "mr_ctl_defs.svh"

module mr_translate (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cfg_wr_en,
    input  logic [`MR_KEY_LOG-1:0]            cfg_key,
    input  logic                              cfg_key_valid,
    input  logic [`MR_ADDR_WIDTH-1:0]         cfg_base,
    input  logic [`MR_OFFSET_WIDTH-1:0]       cfg_len,
    input  logic                              issue_valid,
    input  logic [`MR_TAG_LOG-1:0]            issue_tag,
    input  logic [`MR_KEY_LOG-1:0]            issue_key,
    input  logic [`MR_OFFSET_WIDTH-1:0]       issue_offset,
    output logic                              issue_ready,
    output logic                              mr_rsp_valid,
    output logic [`MR_TAG_LOG-1:0]            mr_rsp_tag,
    output logic [`MR_RESP_DATA_WIDTH-1:0]    mr_rsp_data,
    input  logic                              mr_rsp_ready
);

    localparam int KN = 1 << `MR_KEY_LOG;

    logic [KN-1:0]                 tbl_valid;
    logic [`MR_ADDR_WIDTH-1:0]     tbl_base [KN];
    logic [`MR_OFFSET_WIDTH-1:0]   tbl_len  [KN];

    logic                          stall;
    logic                          s1_valid;
    logic [`MR_TAG_LOG-1:0]        s1_tag;
    logic [`MR_OFFSET_WIDTH-1:0]   s1_offset;
    logic                          s1_ent_valid;
    logic [`MR_ADDR_WIDTH-1:0]     s1_base;
    logic [`MR_OFFSET_WIDTH-1:0]   s1_len;
    logic                          s2_err;
    logic [`MR_ADDR_WIDTH-1:0]     s2_addr;

    // MR table, only the valid bits are cleared
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tbl_valid <= '0;
        end else if (cfg_wr_en) begin
            tbl_valid[cfg_key] <= cfg_key_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr_en) begin
            tbl_base[cfg_key] <= cfg_base;
            tbl_len[cfg_key]  <= cfg_len;
        end
    end

    // Everything freezes while the output is held
    assign stall       = mr_rsp_valid && !mr_rsp_ready;
    assign issue_ready = !stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            mr_rsp_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid     <= issue_valid;
            mr_rsp_valid <= s1_valid;
        end
    end

    // Stage 1 table read
    always_ff @(posedge clk) begin
        if (!stall && issue_valid) begin
            s1_tag       <= issue_tag;
            s1_offset    <= issue_offset;
            s1_ent_valid <= tbl_valid[issue_key];
            s1_base      <= tbl_base[issue_key];
            s1_len       <= tbl_len[issue_key];
        end
    end

    // Stage 2 range check and address sum
    assign s2_err  = !s1_ent_valid || (s1_offset >= s1_len);
    assign s2_addr = s1_base + {{(`MR_ADDR_WIDTH - `MR_OFFSET_WIDTH){1'b0}}, s1_offset};

    always_ff @(posedge clk) begin
        if (!stall && s1_valid) begin
            mr_rsp_tag  <= s1_tag;
            mr_rsp_data <= s2_err ? {1'b1, {`MR_ADDR_WIDTH{1'b0}}} : {1'b0, s2_addr};
        end
    end

endmodule

// File: mr_ctl/mr_rsp_dispatch.sv
`timescale 1ns/100ps
`include "mr_ctl_defs.svh"

module mr_rsp_dispatch (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 mr_rsp_valid,
    input  mr_ctl_pkg::mr_tag_u                                  mr_rsp_tag,
    input  logic [`MR_RESP_DATA_WIDTH-1:0]                       mr_rsp_data,
    output logic                                                 mr_rsp_ready,
    output logic [`MR_TAG_LOG-1:0]                               tbl_rd_tag,
    output logic                                                 tbl_rd_done,
    input  logic [`MR_QPN_LOG-1:0]                               tbl_rd_qpn,
    output logic [`MR_CHNL_NUM-1:0]                              rsp_valid,
    output logic [`MR_CHNL_NUM-1:0][`MR_RESP_HEAD_WIDTH-1:0]     rsp_head,
    output logic [`MR_CHNL_NUM-1:0][`MR_RESP_DATA_WIDTH-1:0]     rsp_data,
    input  logic [`MR_CHNL_NUM-1:0]                              rsp_ready,
    output logic                                                 release_valid,
    output logic [`MR_CHNL_LOG-1:0]                              release_chnl
);

    localparam int NCH = `MR_CHNL_NUM;
    localparam int CL  = `MR_CHNL_LOG;

    // Channel states share the channel number and idle sits just above
    localparam logic [CL-1:0] ST_IDLE = CL'(NCH);

    logic [CL-1:0]                     state;
    logic [CL-1:0]                     state_nxt;
    logic                              rsp_fire;
    mr_ctl_pkg::mr_tag_u               lat_tag;
    logic [`MR_RESP_DATA_WIDTH-1:0]    lat_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        if (state == ST_IDLE) begin
            if (mr_rsp_valid) begin
                case (int'(mr_rsp_tag.f.chnl))
                    mr_ctl_pkg::CHNL_SQ,
                    mr_ctl_pkg::CHNL_RQ,
                    mr_ctl_pkg::CHNL_TX_REQ,
                    mr_ctl_pkg::CHNL_RX_REQ,
                    mr_ctl_pkg::CHNL_RX_RESP: state_nxt = mr_rsp_tag.f.chnl;
                    default:                  state_nxt = ST_IDLE;
                endcase
            end
        end else if (rsp_fire) begin
            state_nxt = ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && mr_rsp_valid) begin
            lat_tag  <= mr_rsp_tag;
            lat_data <= mr_rsp_data;
        end
    end

    assign mr_rsp_ready = (state == ST_IDLE);
    assign rsp_fire     = |(rsp_valid & rsp_ready);

    // QPN lookup runs off the latched tag
    assign tbl_rd_tag    = lat_tag.flat;
    assign tbl_rd_done   = rsp_fire;
    assign release_valid = rsp_fire;
    assign release_chnl  = lat_tag.f.chnl;

    for (genvar c = 0; c < NCH; c++) begin : g_chnl
        assign rsp_valid[c] = (state == CL'(c));
        assign rsp_head[c]  = rsp_valid[c] ?
            {tbl_rd_qpn, {(`MR_TAG_LOG - `MR_LOCAL_TAG_LOG){1'b0}}, lat_tag.f.local_tag} : '0;
        assign rsp_data[c]  = rsp_valid[c] ? lat_data : '0;

        // Head depends on the mapping table staying put
        a_hold: assert property (@(posedge clk) disable iff (rst)
            rsp_valid[c] && !rsp_ready[c] |=>
                rsp_valid[c] && $stable(rsp_head[c]) && $stable(rsp_data[c]));
    end

endmodule

// File: source/mr_ctl_top.sv
`timescale 1ns/100ps
`include "mr_ctl_defs.svh"

module mr_ctl_top (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 cfg_wr_en,
    input  logic [`MR_KEY_LOG-1:0]                               cfg_key,
    input  logic                                                 cfg_key_valid,
    input  logic [`MR_ADDR_WIDTH-1:0]                            cfg_base,
    input  logic [`MR_OFFSET_WIDTH-1:0]                          cfg_len,
    input  logic [`MR_CHNL_NUM-1:0]                              req_valid,
    input  logic [`MR_CHNL_NUM-1:0][`MR_QPN_LOG-1:0]             req_qpn,
    input  logic [`MR_CHNL_NUM-1:0][`MR_KEY_LOG-1:0]             req_key,
    input  logic [`MR_CHNL_NUM-1:0][`MR_OFFSET_WIDTH-1:0]        req_offset,
    output logic [`MR_CHNL_NUM-1:0]                              req_ready,
    output logic [`MR_CHNL_NUM-1:0]                              rsp_valid,
    output logic [`MR_CHNL_NUM-1:0][`MR_RESP_HEAD_WIDTH-1:0]     rsp_head,
    output logic [`MR_CHNL_NUM-1:0][`MR_RESP_DATA_WIDTH-1:0]     rsp_data,
    input  logic [`MR_CHNL_NUM-1:0]                              rsp_ready
);

    // Scheduler to translator
    logic                              issue_valid;
    mr_ctl_pkg::mr_tag_u               issue_tag;
    logic [`MR_KEY_LOG-1:0]            issue_key;
    logic [`MR_OFFSET_WIDTH-1:0]       issue_offset;
    logic                              issue_ready;

    // Mapping table ports
    logic                              tbl_wr_en;
    logic [`MR_TAG_LOG-1:0]            tbl_wr_tag;
    logic [`MR_QPN_LOG-1:0]            tbl_wr_qpn;
    logic [`MR_TAG_LOG-1:0]            tbl_rd_tag;
    logic                              tbl_rd_done;
    logic [`MR_QPN_LOG-1:0]            tbl_rd_qpn;

    // Translator to dispatcher
    logic                              mr_rsp_valid;
    mr_ctl_pkg::mr_tag_u               mr_rsp_tag;
    logic [`MR_RESP_DATA_WIDTH-1:0]    mr_rsp_data;
    logic                              mr_rsp_ready;

    logic                              release_valid;
    logic [`MR_CHNL_LOG-1:0]           release_chnl;

    mr_req_sched i_sched (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_qpn       (req_qpn),
        .req_key       (req_key),
        .req_offset    (req_offset),
        .req_ready     (req_ready),
        .issue_valid   (issue_valid),
        .issue_tag     (issue_tag),
        .issue_key     (issue_key),
        .issue_offset  (issue_offset),
        .issue_ready   (issue_ready),
        .tbl_wr_en     (tbl_wr_en),
        .tbl_wr_tag    (tbl_wr_tag),
        .tbl_wr_qpn    (tbl_wr_qpn),
        .release_valid (release_valid),
        .release_chnl  (release_chnl)
    );

    tag_qpn_table i_tag_tbl (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (tbl_wr_en),
        .wr_tag  (tbl_wr_tag),
        .wr_qpn  (tbl_wr_qpn),
        .rd_tag  (tbl_rd_tag),
        .rd_done (tbl_rd_done),
        .rd_qpn  (tbl_rd_qpn)
    );

    mr_translate i_xlate (
        .clk           (clk),
        .rst           (rst),
        .cfg_wr_en     (cfg_wr_en),
        .cfg_key       (cfg_key),
        .cfg_key_valid (cfg_key_valid),
        .cfg_base      (cfg_base),
        .cfg_len       (cfg_len),
        .issue_valid   (issue_valid),
        .issue_tag     (issue_tag),
        .issue_key     (issue_key),
        .issue_offset  (issue_offset),
        .issue_ready   (issue_ready),
        .mr_rsp_valid  (mr_rsp_valid),
        .mr_rsp_tag    (mr_rsp_tag),
        .mr_rsp_data   (mr_rsp_data),
        .mr_rsp_ready  (mr_rsp_ready)
    );

    mr_rsp_dispatch i_dispatch (
        .clk           (clk),
        .rst           (rst),
        .mr_rsp_valid  (mr_rsp_valid),
        .mr_rsp_tag    (mr_rsp_tag),
        .mr_rsp_data   (mr_rsp_data),
        .mr_rsp_ready  (mr_rsp_ready),
        .tbl_rd_tag    (tbl_rd_tag),
        .tbl_rd_done   (tbl_rd_done),
        .tbl_rd_qpn    (tbl_rd_qpn),
        .rsp_valid     (rsp_valid),
        .rsp_head      (rsp_head),
        .rsp_data      (rsp_data),
        .rsp_ready     (rsp_ready),
        .release_valid (release_valid),
        .release_chnl  (release_chnl)
    );

endmodule

// File: dv/tb_mr_ctl.sv
`timescale 1ns/100ps
`include "mr_ctl_defs.svh"

module tb_mr_ctl;

    localparam int NCH   = `MR_CHNL_NUM;
    localparam int HW    = `MR_RESP_HEAD_WIDTH;
    localparam int DW    = `MR_RESP_DATA_WIDTH;
    localparam int ROWS  = 40;
    localparam int CFGS  = 6;
    localparam int LIMIT = ROWS * 40 + 200;

    // Row fields channel[46:44], QPN[43:36], key[35:32], offset[31:0]
    localparam logic [46:0] STIM [ROWS] = '{
        {3'd0, 8'h10, 4'd1, 32'h0000_0040}, {3'd1, 8'h21, 4'd2, 32'h0000_0200},
        {3'd2, 8'h32, 4'd3, 32'h0000_0010}, {3'd3, 8'h43, 4'd1, 32'h0000_1000},
        {3'd4, 8'h54, 4'd7, 32'h0000_1800}, {3'd0, 8'h60, 4'd5, 32'hffff_fffe},
        {3'd0, 8'h61, 4'd1, 32'h0000_0fff}, {3'd0, 8'h62, 4'd2, 32'h0000_03ff},
        {3'd0, 8'h63, 4'd0, 32'h0000_0000}, {3'd0, 8'h64, 4'd9, 32'h0000_0000},
        {3'd0, 8'h65, 4'd5, 32'hffff_ffff}, {3'd0, 8'h66, 4'd7, 32'h0000_0ffc},
        {3'd0, 8'h67, 4'd1, 32'h0000_0800}, {3'd0, 8'h68, 4'd2, 32'h0000_0100},
        {3'd0, 8'h69, 4'd3, 32'h0000_0000}, {3'd0, 8'h6a, 4'd7, 32'h0000_2000},
        {3'd0, 8'h6b, 4'd5, 32'h1234_5678}, {3'd0, 8'h6c, 4'd1, 32'h0000_0001},
        {3'd0, 8'h6d, 4'd2, 32'h0000_0000}, {3'd0, 8'h6e, 4'd7, 32'h0000_1fff},
        {3'd4, 8'h9a, 4'd2, 32'h0000_0180}, {3'd0, 8'h6f, 4'd1, 32'h8000_0000},
        {3'd0, 8'h70, 4'd5, 32'h0000_0000}, {3'd0, 8'h71, 4'd1, 32'h0000_0abc},
        {3'd0, 8'h72, 4'd2, 32'h0000_0300}, {3'd0, 8'h73, 4'd9, 32'h0000_0004},
        {3'd0, 8'h74, 4'd7, 32'h0000_0010}, {3'd0, 8'h75, 4'd5, 32'h7fff_ffff},
        {3'd0, 8'h76, 4'd1, 32'h0000_0004}, {3'd0, 8'h77, 4'd2, 32'h0000_0101},
        {3'd3, 8'hb6, 4'd2, 32'h0000_0400}, {3'd0, 8'h78, 4'd7, 32'h0000_1234},
        {3'd0, 8'h79, 4'd1, 32'h0000_0ff0}, {3'd0, 8'h7a, 4'd0, 32'h0000_0010},
        {3'd0, 8'h7b, 4'd5, 32'h0000_1000}, {3'd0, 8'h7c, 4'd2, 32'h0000_03fe},
        {3'd0, 8'h7d, 4'd1, 32'h0000_0002}, {3'd0, 8'h7e, 4'd7, 32'h0000_0800},
        {3'd0, 8'h7f, 4'd1, 32'h0000_0100}, {3'd1, 8'hc7, 4'd9, 32'h0000_0000}
    };

    // Entry fields key[84:81], valid[80], base[79:32], length[31:0]
    localparam logic [84:0] CFG [CFGS] = '{
        {4'd1, 1'b1, 48'h0000_1000_0000, 32'h0000_1000},
        {4'd2, 1'b1, 48'h0000_ffff_ff00, 32'h0000_0400},
        {4'd3, 1'b0, 48'h0000_2000_0000, 32'h0000_0100},
        {4'd5, 1'b1, 48'h8000_0000_0000, 32'hffff_ffff},
        {4'd7, 1'b1, 48'hffff_ffff_f000, 32'h0000_2000},
        {4'd9, 1'b1, 48'h0000_0002_0000, 32'h0000_0000}
    };

    logic                                             clk = 1'b0;
    logic                                             rst;
    logic                                             cfg_wr_en;
    logic [`MR_KEY_LOG-1:0]                           cfg_key;
    logic                                             cfg_key_valid;
    logic [`MR_ADDR_WIDTH-1:0]                        cfg_base;
    logic [`MR_OFFSET_WIDTH-1:0]                      cfg_len;
    logic [NCH-1:0]                                   req_valid;
    logic [NCH-1:0][`MR_QPN_LOG-1:0]                  req_qpn;
    logic [NCH-1:0][`MR_KEY_LOG-1:0]                  req_key;
    logic [NCH-1:0][`MR_OFFSET_WIDTH-1:0]             req_offset;
    logic [NCH-1:0]                                   req_ready;
    logic [NCH-1:0]                                   rsp_valid;
    logic [NCH-1:0][HW-1:0]                           rsp_head;
    logic [NCH-1:0][DW-1:0]                           rsp_data;
    logic [NCH-1:0]                                   rsp_ready = '0;

    // Reference copy of the MR table
    logic                          m_valid [16];
    logic [`MR_ADDR_WIDTH-1:0]     m_base  [16];
    logic [`MR_OFFSET_WIDTH-1:0]   m_len   [16];

    // Expected responses per channel in request order
    logic [HW-1:0]   exp_head [NCH][ROWS];
    logic [DW-1:0]   exp_data [NCH][ROWS];
    int              sent_cnt [NCH];
    int              acc_cnt  [NCH];
    int              rsp_cnt  [NCH];

    logic            held      [NCH];
    logic [HW-1:0]   held_head [NCH];
    logic [DW-1:0]   held_data [NCH];

    int              main_errs;
    int              mon_errs;
    int              cycle_cnt;
    int              seed = 36067;
    logic [31:0]     rnd;

    mr_ctl_top i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [DW-1:0] expect_data(input logic [3:0] key,
                                                  input logic [31:0] offset);
        logic [`MR_ADDR_WIDTH-1:0] addr;
        if (!m_valid[key] || offset >= m_len[key]) begin
            return {1'b1, 48'h0};
        end
        addr = m_base[key] + {16'h0, offset};
        return {1'b0, addr};
    endfunction

    function automatic logic all_answered();
        for (int c = 0; c < NCH; c++) begin
            if (rsp_cnt[c] != sent_cnt[c]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_idle(input string phase);
        if (req_ready != '0) begin
            $display("FAIL req_ready %s: got %h expected %h", phase, req_ready, 5'h0);
            main_errs++;
        end
        if (rsp_valid != '0) begin
            $display("FAIL rsp_valid %s: got %h expected %h", phase, rsp_valid, 5'h0);
            main_errs++;
        end
    endtask

    task automatic program_mr_table();
        for (int k = 0; k < 16; k++) begin
            m_valid[k] = 1'b0;
        end
        for (int i = 0; i < CFGS; i++) begin
            @(negedge clk);
            cfg_wr_en     = 1'b1;
            cfg_key       = CFG[i][84:81];
            cfg_key_valid = CFG[i][80];
            cfg_base      = CFG[i][79:32];
            cfg_len       = CFG[i][31:0];
            m_valid[CFG[i][84:81]] = CFG[i][80];
            m_base[CFG[i][84:81]]  = CFG[i][79:32];
            m_len[CFG[i][84:81]]   = CFG[i][31:0];
        end
        @(negedge clk);
        cfg_wr_en = 1'b0;
    endtask

    // Drop valid on channels whose last request was taken
    task automatic retire_accepted();
        for (int c = 0; c < NCH; c++) begin
            if (req_valid[c] && acc_cnt[c] == sent_cnt[c]) begin
                req_valid[c] = 1'b0;
            end
        end
    endtask

    task automatic drive_row(input logic [46:0] row);
        int ch;
        ch = int'(row[46:44]);
        while (req_valid[ch]) begin
            @(negedge clk);
            retire_accepted();
        end
        req_valid[ch]  = 1'b1;
        req_qpn[ch]    = row[43:36];
        req_key[ch]    = row[35:32];
        req_offset[ch] = row[31:0];
        exp_head[ch][sent_cnt[ch]] = {row[43:36], 8'(sent_cnt[ch] % 32)};
        exp_data[ch][sent_cnt[ch]] = expect_data(row[35:32], row[31:0]);
        sent_cnt[ch]++;
    endtask

    initial begin
        rst           = 1'b1;
        cfg_wr_en     = 1'b0;
        cfg_key       = '0;
        cfg_key_valid = 1'b0;
        cfg_base      = '0;
        cfg_len       = '0;
        req_valid     = '0;
        req_qpn       = '0;
        req_key       = '0;
        req_offset    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_idle("in reset");
        rst = 1'b0;
        @(negedge clk);
        check_idle("after reset");
        program_mr_table();
        for (int r = 0; r < ROWS; r++) begin
            drive_row(STIM[r]);
        end
        while (req_valid != '0) begin
            @(negedge clk);
            retire_accepted();
        end
        while (!all_answered()) begin
            @(negedge clk);
        end
        // Extra cycles catch any duplicated response
        repeat (10) @(negedge clk);
        $display("Errors: %0d in sequence checks, %0d in response checks",
                 main_errs, mon_errs);
        if (main_errs + mon_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Random back-pressure on the response side
    always @(negedge clk) begin
        rnd       = $random(seed);
        rsp_ready = rnd[NCH-1:0];
    end

    always @(posedge clk) begin
        if (!rst) begin
            for (int c = 0; c < NCH; c++) begin
                if (req_valid[c] && req_ready[c]) begin
                    acc_cnt[c]++;
                end
                if (held[c] && (!rsp_valid[c] || rsp_head[c] != held_head[c] ||
                                rsp_data[c] != held_data[c])) begin
                    $display("Channel %0d dropped or changed a response before it was taken", c);
                    mon_errs++;
                end
                held[c]      = rsp_valid[c] && !rsp_ready[c];
                held_head[c] = rsp_head[c];
                held_data[c] = rsp_data[c];
                if (!rsp_valid[c] && rsp_head[c] != '0) begin
                    $display("FAIL ch%0d rsp_head idle: got %h expected %h",
                             c, rsp_head[c], 16'h0);
                    mon_errs++;
                end
                if (!rsp_valid[c] && rsp_data[c] != '0) begin
                    $display("FAIL ch%0d rsp_data idle: got %h expected %h",
                             c, rsp_data[c], 49'h0);
                    mon_errs++;
                end
                if (rsp_valid[c] && rsp_ready[c]) begin
                    if (rsp_cnt[c] >= sent_cnt[c]) begin
                        $display("Channel %0d returned a response that no request asked for", c);
                        mon_errs++;
                    end else begin
                        if (rsp_head[c] != exp_head[c][rsp_cnt[c]]) begin
                            $display("FAIL ch%0d rsp_head: got %h expected %h",
                                     c, rsp_head[c], exp_head[c][rsp_cnt[c]]);
                            mon_errs++;
                        end
                        if (rsp_data[c] != exp_data[c][rsp_cnt[c]]) begin
                            $display("FAIL ch%0d rsp_data: got %h expected %h",
                                     c, rsp_data[c], exp_data[c][rsp_cnt[c]]);
                            mon_errs++;
                        end
                        rsp_cnt[c]++;
                    end
                end
            end
            if (!$onehot0(rsp_valid)) begin
                $display("More than one channel had a response at the same time");
                mon_errs++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == LIMIT) begin
            $display("Timeout: responses still missing after %0d cycles, %0d errors so far",
                     LIMIT, main_errs + mon_errs);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+common
common/mr_ctl_pkg.sv
mr_ctl/mr_req_sched.sv
mr_ctl/tag_qpn_table.sv
mr_ctl/mr_translate.sv
mr_ctl/mr_rsp_dispatch.sv
source/mr_ctl_top.sv
dv/tb_mr_ctl.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_mr_ctl -o tb_mr_ctl \
    && ./obj_dir/tb_mr_ctl | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
